/* hdl/pwm_pkg.sv */
// Shared register offsets, widths and control word layout; imported by every PWM RTL module
package pwm_pkg;

    // Register offsets on the strobe bus
    localparam logic [7:0] ctrl_offset    = 8'h00;
    localparam logic [7:0] compare_offset = 8'h04;
    localparam logic [7:0] period_offset  = 8'h08;
    localparam logic [7:0] mask_offset    = 8'h0C;

    // Shadow register select, taken from address bits 3:2
    localparam logic [1:0] select_compare = 2'd1;
    localparam logic [1:0] select_period  = 2'd2;
    localparam logic [1:0] select_mask    = 2'd3;

    // Datapath widths
    localparam int counter_width  = 16;
    localparam int out_width      = 12;
    localparam int prescale_width = 3;

    // Control word with sync flag clear
    typedef struct packed {
        logic [11:0]                reserved;
        logic [out_width-1:0]       stopped_state;
        logic                       sync_flag;
        logic                       stop_request;
        logic                       run;
        logic                       external_enable;
        logic                       timebase_enable;
        logic [prescale_width-1:0]  prescale;
    } control_config_t;

    // Sync view of the control word ignores the low fields
    typedef struct packed {
        logic [7:0]                 reserved;
        logic [counter_width-1:0]   phase;
        logic                       sync_flag;
        logic [6:0]                 common;
    } control_sync_t;

    // Bit 7 picks which view applies
    typedef union packed {
        control_config_t config_view;
        control_sync_t   sync_view;
    } control_word_t;

endpackage

/* hdl/pwm_timebase.sv */
// Prescaler for the PWM counter; emits count ticks from the divided clock or an external tick
`timescale 1ns/1ps

module pwm_timebase
    import pwm_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,
    input  logic [prescale_width-1:0]   prescale_setting,
    input  logic                        timebase_enable,
    input  logic                        external_enable,
    input  logic                        external_tick,
    input  logic                        sync,
    output logic                        tick
);

    // Largest division is two to the power of the top setting
    logic [2**prescale_width-2:0] divider;
    logic [2**prescale_width-2:0] divide_mask;
    logic [1:0]                   external_sync;
    logic                         external_prev;
    logic                         external_rise;
    logic                         internal_tick;

    assign divide_mask   = ~({(2**prescale_width-1){1'b1}} << prescale_setting);
    assign internal_tick = (divider & divide_mask) == divide_mask;
    assign external_rise = external_sync[1] & ~external_prev;

    assign tick = timebase_enable & (external_enable ? external_rise : internal_tick);

    always_ff @(posedge clock) begin
        if (!reset) begin
            divider <= '0;
        end else if (sync) begin
            divider <= '0;
        end else if (timebase_enable && !external_enable) begin
            divider <= divider + 1'b1;
        end
    end

    // Two stages for the asynchronous pin, one more for the edge
    always_ff @(posedge clock) begin
        if (!reset) begin
            external_sync <= '0;
            external_prev <= 1'b0;
        end else begin
            external_sync <= {external_sync[0], external_tick};
            external_prev <= external_sync[1];
        end
    end

endmodule

/* hdl/pwm_control_unit.sv */
// Bus write front end for the PWM block; decodes control writes and forwards shadow register writes
`timescale 1ns/1ps

module pwm_control_unit
    import pwm_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,
    input  logic [7:0]                  address,
    input  logic [31:0]                 write_data,
    input  logic                        write_strobe,
    input  logic                        counter_busy,
    output logic                        ready,
    output logic [prescale_width-1:0]   prescale_setting,
    output logic                        timebase_enable,
    output logic                        external_enable,
    output logic                        counter_run,
    output logic                        stop_request,
    output logic                        sync,
    output logic [counter_width-1:0]    sync_phase,
    output logic [out_width-1:0]        stopped_state,
    output logic                        reg_write,
    output logic [1:0]                  reg_select,
    output logic [15:0]                 reg_data
);

    typedef enum logic [1:0] {
        idle_state,
        act_state,
        soft_stop_state
    } state_t;

    state_t        state;
    logic          act_ended;
    logic          write_accept;
    logic [7:0]    latched_address;
    logic [31:0]   latched_data;
    control_word_t control_word;

    assign write_accept = write_strobe & ready;

    // Latched word seen through both views
    assign control_word = control_word_t'(latched_data);

    // Held stable by the latch until the FSM is idle again
    assign reg_select = latched_address[3:2];
    assign reg_data   = latched_data[15:0];
    assign sync_phase = control_word.sync_view.phase;

    // Capture address and data only on accepted writes
    always_ff @(posedge clock) begin
        if (write_accept && state == idle_state) begin
            latched_address <= address;
            latched_data    <= write_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state            <= idle_state;
            act_ended        <= 1'b0;
            ready            <= 1'b1;
            prescale_setting <= '0;
            timebase_enable  <= 1'b0;
            external_enable  <= 1'b0;
            counter_run      <= 1'b0;
            stop_request     <= 1'b0;
            sync             <= 1'b0;
            stopped_state    <= '0;
            reg_write        <= 1'b0;
        end else begin
            // Pulses last one cycle
            sync      <= 1'b0;
            reg_write <= 1'b0;

            case (state)
                idle_state: begin
                    act_ended <= 1'b0;
                    if (write_accept) begin
                        ready <= 1'b0;
                        state <= act_state;
                    end
                end

                act_state: begin
                    if (act_ended) begin
                        // Second act cycle closes the write
                        act_ended <= 1'b0;
                        ready     <= 1'b1;
                        state     <= idle_state;
                    end else begin
                        act_ended <= 1'b1;
                        case (latched_address)
                            ctrl_offset: begin
                                if (control_word.sync_view.sync_flag) begin
                                    sync <= 1'b1;
                                end else begin
                                    // Timebase changes only on an idle counter
                                    if (!counter_busy) begin
                                        prescale_setting <= control_word.config_view.prescale;
                                        timebase_enable  <=
                                            control_word.config_view.timebase_enable;
                                        external_enable  <=
                                            control_word.config_view.external_enable;
                                    end
                                    stopped_state <= control_word.config_view.stopped_state;
                                    if (control_word.config_view.stop_request) begin
                                        // Run stays up until the counter reaches zero
                                        stop_request <= 1'b1;
                                        state        <= soft_stop_state;
                                    end else begin
                                        counter_run <= control_word.config_view.run;
                                    end
                                end
                            end
                            compare_offset,
                            period_offset,
                            mask_offset: begin
                                reg_write <= 1'b1;
                            end
                            default: begin
                                // Unmapped offsets are dropped
                            end
                        endcase
                    end
                end

                soft_stop_state: begin
                    if (!counter_busy) begin
                        stop_request <= 1'b0;
                        counter_run  <= 1'b0;
                        ready        <= 1'b1;
                        state        <= idle_state;
                    end
                end

                default: begin
                    ready <= 1'b1;
                    state <= idle_state;
                end
            endcase
        end
    end

endmodule

/* hdl/pwm_shadow_regs.sv */
// Pending and active copies of compare, period and mask; active set updates at period boundaries
`timescale 1ns/1ps

module pwm_shadow_regs
    import pwm_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        reg_write,
    input  logic [1:0]                  reg_select,
    input  logic [15:0]                 reg_data,
    input  logic                        period_end,
    input  logic                        counter_run,
    output logic [counter_width-1:0]    active_compare,
    output logic [counter_width-1:0]    active_period,
    output logic [out_width-1:0]        active_mask
);

    logic [counter_width-1:0] pending_compare;
    logic [counter_width-1:0] pending_period;
    logic [out_width-1:0]     pending_mask;
    logic                     write_seen;
    logic                     transfer;

    // Stopped counter takes new values one cycle after the write
    assign transfer = period_end | (write_seen & ~counter_run);

    always_ff @(posedge clock) begin
        if (reg_write) begin
            case (reg_select)
                select_compare: pending_compare <= reg_data;
                select_period:  pending_period  <= reg_data;
                select_mask:    pending_mask    <= reg_data[out_width-1:0];
                default:        pending_compare <= pending_compare;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            write_seen     <= 1'b0;
            active_compare <= '0;
            active_period  <= '0;
            active_mask    <= '0;
        end else begin
            write_seen <= reg_write;
            if (transfer) begin
                active_compare <= pending_compare;
                active_period  <= pending_period;
                active_mask    <= pending_mask;
            end
        end
    end

endmodule

/* hdl/pwm_counter_core.sv */
// PWM period counter with compare and output selection; consumes the active shadow registers
`timescale 1ns/1ps

module pwm_counter_core
    import pwm_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,
    input  logic [prescale_width-1:0]   prescale_setting,
    input  logic                        timebase_enable,
    input  logic                        external_enable,
    input  logic                        external_tick,
    input  logic                        counter_run,
    input  logic                        stop_request,
    input  logic                        sync,
    input  logic [counter_width-1:0]    sync_phase,
    input  logic [out_width-1:0]        stopped_state,
    input  logic [counter_width-1:0]    active_compare,
    input  logic [counter_width-1:0]    active_period,
    input  logic [out_width-1:0]        active_mask,
    output logic                        counter_busy,
    output logic                        period_end,
    output logic [counter_width-1:0]    counter_value,
    output logic [out_width-1:0]        pwm_out
);

    logic tick;
    logic last_count;
    logic holding;
    logic advance;

    pwm_timebase u_timebase (
        .clock            (clock),
        .reset            (reset),
        .prescale_setting (prescale_setting),
        .timebase_enable  (timebase_enable),
        .external_enable  (external_enable),
        .external_tick    (external_tick),
        .sync             (sync),
        .tick             (tick)
    );

    assign counter_busy = |counter_value;

    // Extra bit keeps a zero period from wrapping the compare
    assign last_count = ({1'b0, counter_value} + {{counter_width{1'b0}}, 1'b1})
                        >= {1'b0, active_period};

    // A stop request parks the counter once it is back at zero
    assign holding    = stop_request & ~counter_busy;
    assign advance    = tick & counter_run & ~holding;
    assign period_end = advance & last_count & ~sync;

    always_ff @(posedge clock) begin
        if (!reset) begin
            counter_value <= '0;
        end else if (sync) begin
            counter_value <= sync_phase;
        end else if (!counter_run) begin
            counter_value <= '0;
        end else if (advance) begin
            if (last_count) begin
                counter_value <= '0;
            end else begin
                counter_value <= counter_value + 1'b1;
            end
        end
    end

    // Pattern from the compare while running, fixed state otherwise
    always_comb begin
        if (!counter_run) begin
            pwm_out = stopped_state;
        end else if (counter_value < active_compare) begin
            pwm_out = active_mask;
        end else begin
            pwm_out = '0;
        end
    end

endmodule

/* hdl/pwm_subsystem.sv */
// Top level of the PWM generator; connects the strobe bus and external tick to the PWM pins
`timescale 1ns/1ps

module pwm_subsystem
    import pwm_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,
    input  logic [7:0]                  address,
    input  logic [31:0]                 write_data,
    input  logic                        write_strobe,
    output logic                        ready,
    input  logic                        external_tick,
    output logic [out_width-1:0]        pwm_out,
    output logic [counter_width-1:0]    counter_value
);

    logic [prescale_width-1:0] prescale_setting;
    logic                      timebase_enable;
    logic                      external_enable;
    logic                      counter_run;
    logic                      stop_request;
    logic                      sync;
    logic [counter_width-1:0]  sync_phase;
    logic [out_width-1:0]      stopped_state;
    logic                      reg_write;
    logic [1:0]                reg_select;
    logic [15:0]               reg_data;
    logic                      counter_busy;
    logic                      period_end;
    logic [counter_width-1:0]  active_compare;
    logic [counter_width-1:0]  active_period;
    logic [out_width-1:0]      active_mask;

    pwm_control_unit u_control (
        .clock            (clock),
        .reset            (reset),
        .address          (address),
        .write_data       (write_data),
        .write_strobe     (write_strobe),
        .counter_busy     (counter_busy),
        .ready            (ready),
        .prescale_setting (prescale_setting),
        .timebase_enable  (timebase_enable),
        .external_enable  (external_enable),
        .counter_run      (counter_run),
        .stop_request     (stop_request),
        .sync             (sync),
        .sync_phase       (sync_phase),
        .stopped_state    (stopped_state),
        .reg_write        (reg_write),
        .reg_select       (reg_select),
        .reg_data         (reg_data)
    );

    pwm_shadow_regs u_shadow (
        .clock          (clock),
        .reset          (reset),
        .reg_write      (reg_write),
        .reg_select     (reg_select),
        .reg_data       (reg_data),
        .period_end     (period_end),
        .counter_run    (counter_run),
        .active_compare (active_compare),
        .active_period  (active_period),
        .active_mask    (active_mask)
    );

    pwm_counter_core u_core (
        .clock            (clock),
        .reset            (reset),
        .prescale_setting (prescale_setting),
        .timebase_enable  (timebase_enable),
        .external_enable  (external_enable),
        .external_tick    (external_tick),
        .counter_run      (counter_run),
        .stop_request     (stop_request),
        .sync             (sync),
        .sync_phase       (sync_phase),
        .stopped_state    (stopped_state),
        .active_compare   (active_compare),
        .active_period    (active_period),
        .active_mask      (active_mask),
        .counter_busy     (counter_busy),
        .period_end       (period_end),
        .counter_value    (counter_value),
        .pwm_out          (pwm_out)
    );

endmodule

/* test/pwm_tb.sv */
// Testbench for the PWM subsystem; drives the strobe bus and checks pwm_out against a model
`timescale 1ns/1ps

module pwm_tb
    import pwm_pkg::*;
();

    localparam int timeout_cycles = 200;
    localparam int period_length  = 20;

    logic                     clock;
    logic                     reset;
    logic [7:0]               address;
    logic [31:0]              write_data;
    logic                     write_strobe;
    logic                     ready;
    logic                     external_tick;
    logic [out_width-1:0]     pwm_out;
    logic [counter_width-1:0] counter_value;

    integer seed = 32'h120d_0ffa;
    integer error_count = 0;
    integer check_count = 0;
    integer test_count = 0;
    integer test_start_errors = 0;
    logic   checking = 1'b0;

    // Model of the committed registers in pending and active copies
    logic                     model_run = 1'b0;
    logic [out_width-1:0]     model_stopped = '0;
    logic [counter_width-1:0] pending_compare = '0;
    logic [counter_width-1:0] active_compare = '0;
    logic [out_width-1:0]     pending_mask = '0;
    logic [out_width-1:0]     active_mask = '0;

    // State seen at the previous sample for wrap detection
    logic                     prev_run = 1'b0;
    logic [counter_width-1:0] prev_count = '0;
    logic [counter_width-1:0] prev_compare = '0;
    logic [out_width-1:0]     prev_mask = '0;

    logic [counter_width-1:0] duty_compare;
    logic [counter_width-1:0] old_compare;
    logic [counter_width-1:0] phase;
    logic [counter_width-1:0] last_count;
    integer                   changes;
    integer                   wait_count;

    pwm_subsystem DUT (
        .clock         (clock),
        .reset         (reset),
        .address       (address),
        .write_data    (write_data),
        .write_strobe  (write_strobe),
        .ready         (ready),
        .external_tick (external_tick),
        .pwm_out       (pwm_out),
        .counter_value (counter_value)
    );

    initial clock = 1'b0;
    always #50 clock = ~clock;

    // Mask below compare while running, stopped state otherwise
    function automatic logic [out_width-1:0] expected_pwm(
        input logic [counter_width-1:0] count,
        input logic [counter_width-1:0] compare,
        input logic [out_width-1:0]     mask,
        input logic                     run,
        input logic [out_width-1:0]     stopped
    );
        if (!run) begin
            return stopped;
        end
        if (count < compare) begin
            return mask;
        end
        return '0;
    endfunction

    function automatic logic [31:0] config_word(
        input logic [prescale_width-1:0] prescale,
        input logic                      run,
        input logic                      stop,
        input logic [out_width-1:0]      stopped
    );
        control_word_t word;
        word = '0;
        word.config_view.prescale        = prescale;
        word.config_view.timebase_enable = 1'b1;
        word.config_view.run             = run;
        word.config_view.stop_request    = stop;
        word.config_view.stopped_state   = stopped;
        return word;
    endfunction

    function automatic logic [31:0] sync_word(input logic [counter_width-1:0] load_phase);
        control_word_t word;
        word = '0;
        word.sync_view.sync_flag = 1'b1;
        word.sync_view.phase     = load_phase;
        return word;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic timeout_error(input string what);
        error_count++;
        $display("Timeout at %0t: %s", $time, what);
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #10;
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("Test %0d (%s) finished with %0d mismatches",
                 test_count, name, error_count - test_start_errors);
        test_start_errors = error_count;
    endtask

    task automatic wait_for_count(input logic [counter_width-1:0] value);
        integer count_wait;
        count_wait = 0;
        while (counter_value !== value && count_wait < timeout_cycles) begin
            next_cycle();
            count_wait++;
        end
        if (counter_value !== value) begin
            timeout_error("counter_value never reached the awaited count");
        end
    endtask

    // One write with the handshake checked and the model committed on the right edge
    task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
        control_word_t word;
        integer        ready_wait;
        logic          done;
        word = control_word_t'(data);
        ready_wait = 0;
        while (ready !== 1'b1 && ready_wait < timeout_cycles) begin
            next_cycle();
            ready_wait++;
        end
        if (ready !== 1'b1) begin
            timeout_error("ready stayed low before a bus write");
        end
        address      = addr;
        write_data   = data;
        write_strobe = 1'b1;
        next_cycle();
        write_strobe = 1'b0;
        check_value("ready", 32'd0, ready);
        next_cycle();
        check_value("ready", 32'd0, ready);
        // Control fields land on the first act edge
        if (addr == ctrl_offset && !word.sync_view.sync_flag) begin
            model_stopped = word.config_view.stopped_state;
            if (!word.config_view.stop_request) begin
                model_run = word.config_view.run;
            end
        end
        if (addr == ctrl_offset && !word.sync_view.sync_flag &&
            word.config_view.stop_request) begin
            done = 1'b0;
            ready_wait = 0;
            while (!done && ready_wait < timeout_cycles) begin
                if (counter_value !== '0) begin
                    check_value("ready", 32'd0, ready);
                end
                done = (ready === 1'b1);
                if (!done) begin
                    next_cycle();
                    ready_wait++;
                end
            end
            if (!done) begin
                timeout_error("soft stop never returned ready");
            end
            model_run = 1'b0;
        end else begin
            next_cycle();
            check_value("ready", 32'd1, ready);
            if (addr == compare_offset) begin
                pending_compare = data[counter_width-1:0];
            end
            if (addr == mask_offset) begin
                pending_mask = data[out_width-1:0];
            end
            // Stopped counter copies the pending set one cycle later
            if (addr != ctrl_offset && !model_run) begin
                next_cycle();
                active_compare = pending_compare;
                active_mask    = pending_mask;
            end
        end
    endtask

    // Counts mask cycles over one full period starting at zero
    task automatic measure_duty(input integer expected);
        integer high_count;
        wait_for_count('0);
        high_count = 0;
        repeat (period_length) begin
            if (pwm_out === active_mask) begin
                high_count++;
            end
            next_cycle();
        end
        check_value("duty_count", expected, high_count);
        check_value("counter_value", 32'd0, counter_value);
    endtask

    // Compares pwm_out with the reference on every falling edge
    always @(negedge clock) begin
        if (checking) begin
            if (prev_run && counter_value === '0 && prev_count !== '0) begin
                active_compare = prev_compare;
                active_mask    = prev_mask;
            end
            check_value("pwm_out", expected_pwm(counter_value, active_compare, active_mask,
                                                model_run, model_stopped), pwm_out);
        end
        prev_run     = model_run;
        prev_count   = counter_value;
        prev_compare = pending_compare;
        prev_mask    = pending_mask;
    end

    initial begin
        reset         = 1'b0;
        address       = '0;
        write_data    = '0;
        write_strobe  = 1'b0;
        external_tick = 1'b0;
        repeat (3) @(posedge clock);
        #10;
        reset    = 1'b1;
        checking = 1'b1;

        check_value("pwm_out", 32'd0, pwm_out);
        check_value("ready", 32'd1, ready);
        bus_write(compare_offset, 32'd5);
        end_test("reset and handshake");

        duty_compare = 1 + ({$random(seed)} % (period_length - 1));
        bus_write(period_offset, period_length);
        bus_write(compare_offset, duty_compare);
        bus_write(mask_offset, ({$random(seed)} & 32'hFFF) | 32'h1);
        bus_write(ctrl_offset, config_word(3'd0, 1'b1, 1'b0, 12'h000));
        repeat (3) measure_duty(duty_compare);
        end_test("duty cycle");

        old_compare  = active_compare;
        duty_compare = 1 + ({$random(seed)} % (period_length - 1));
        if (duty_compare == old_compare) begin
            duty_compare = (old_compare % (period_length - 1)) + 1;
        end
        wait_for_count(16'd5);
        bus_write(compare_offset, duty_compare);
        wait_count = 0;
        while (counter_value !== '0 && wait_count < timeout_cycles) begin
            check_value("pwm_out", expected_pwm(counter_value, old_compare, active_mask,
                                                1'b1, model_stopped), pwm_out);
            next_cycle();
            wait_count++;
        end
        measure_duty(duty_compare);
        end_test("shadow transfer");

        bus_write(ctrl_offset, config_word(3'd0, 1'b1, 1'b1, out_width'($random(seed))));
        repeat (5) begin
            check_value("counter_value", 32'd0, counter_value);
            check_value("pwm_out", model_stopped, pwm_out);
            next_cycle();
        end
        end_test("soft stop");

        bus_write(ctrl_offset, config_word(3'd0, 1'b1, 1'b0, model_stopped));
        wait_for_count(16'd3);
        bus_write(ctrl_offset, config_word(3'd2, 1'b1, 1'b0, model_stopped));
        last_count = counter_value;
        repeat (10) begin
            next_cycle();
            check_value("counter_value", (last_count + 1) % period_length, counter_value);
            last_count = counter_value;
        end
        bus_write(ctrl_offset, config_word(3'd2, 1'b1, 1'b1, model_stopped));
        bus_write(ctrl_offset, config_word(3'd2, 1'b1, 1'b0, model_stopped));
        changes    = 0;
        last_count = counter_value;
        repeat (40) begin
            next_cycle();
            if (counter_value !== last_count) begin
                changes++;
            end
            last_count = counter_value;
        end
        check_value("counter_steps", 32'd10, changes);
        end_test("timebase while running");

        bus_write(ctrl_offset, config_word(3'd0, 1'b1, 1'b1, model_stopped));
        bus_write(ctrl_offset, config_word(3'd0, 1'b1, 1'b0, model_stopped));
        // Upper half of the period, away from the count a missed load would show
        phase = period_length / 2 + ({$random(seed)} % (period_length / 2));
        bus_write(ctrl_offset, sync_word(phase));
        check_value("counter_value", phase, counter_value);
        repeat (4) begin
            last_count = counter_value;
            next_cycle();
            check_value("counter_value", (last_count + 1) % period_length, counter_value);
        end
        end_test("sync");

        checking = 1'b0;
        $display("Summary: %0d tests, %0d checks, %0d mismatches",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* list.f */
hdl/pwm_pkg.sv
hdl/pwm_timebase.sv
hdl/pwm_control_unit.sv
hdl/pwm_shadow_regs.sv
hdl/pwm_counter_core.sv
hdl/pwm_subsystem.sv
test/pwm_tb.sv

/* Bender.yml */
package:
  name: pwm_subsystem

sources:
  - hdl/pwm_pkg.sv
  - hdl/pwm_timebase.sv
  - hdl/pwm_control_unit.sv
  - hdl/pwm_shadow_regs.sv
  - hdl/pwm_counter_core.sv
  - hdl/pwm_subsystem.sv
  - target: test
    files:
      - test/pwm_tb.sv
